// ==== design/enc8b10b_config.svh ====
//**************************************************************************
// 8b/10b codec configuration
// Byte and link word widths, K28 control byte values for packet framing
//**************************************************************************

`ifndef ENC8B10B_CONFIG_SVH
`define ENC8B10B_CONFIG_SVH

// Byte and 10-bit link word widths
`define ENC_DATA_W 8
`define ENC_CODE_W 10

// K28.1, start of packet
`define K_SOP   8'h3C
// K28.6, end of packet
`define K_EOP   8'hDC
// K28.5 comma, also sent as idle
`define K_COMMA 8'hBC

`endif

// ==== design/enc8b10b_pkg.sv ====
//**************************************************************************
// 8b/10b codec types
// Frame code seen by the encoder wrapper, running disparity state
//**************************************************************************

package enc8b10b_pkg;

  // Two-bit frame code from the e-link user side
  typedef enum logic [1:0]
  {
    codeData  = 2'b00,
    codeEop   = 2'b01,
    codeSop   = 2'b10,
    codeComma = 2'b11
  } frameCodeT;

  // Running disparity, negative after reset
  typedef enum logic
  {
    dispNeg = 1'b0,
    dispPos = 1'b1
  } dispT;

endpackage

// ==== design/enc8b10b.sv ====
//**************************************************************************
// 8b/10b encoder
// 5b/6b and 3b/4b sub-block lookup with running disparity, registered
// output word and one-cycle valid
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module enc8b10b
  import enc8b10b_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`ENC_DATA_W-1:0] byteIn,
  input  logic                   isK,
  input  logic                   valid,
  output logic [`ENC_CODE_W-1:0] code,
  output logic                   codeValid
);

  dispT       rd;
  dispT       rd6;
  dispT       rdNext;
  logic [4:0] x5;
  logic [2:0] y3;
  logic [5:0] base6;
  logic [5:0] sub6;
  logic [3:0] base4;
  logic [3:0] sub4;
  logic       unbal6;
  logic       unbal4;
  logic       flip4;
  logic       useA7;

  // EDCBA and HGF fields of the byte
  assign x5 = byteIn[4:0];
  assign y3 = byteIn[7:5];

  // 5b/6b, abcdei forms for negative disparity
  always_comb
  begin
    case (x5)
      5'd0:  base6 = 6'b100111;
      5'd1:  base6 = 6'b011101;
      5'd2:  base6 = 6'b101101;
      5'd3:  base6 = 6'b110001;
      5'd4:  base6 = 6'b110101;
      5'd5:  base6 = 6'b101001;
      5'd6:  base6 = 6'b011001;
      5'd7:  base6 = 6'b111000;
      5'd8:  base6 = 6'b111001;
      5'd9:  base6 = 6'b100101;
      5'd10: base6 = 6'b010101;
      5'd11: base6 = 6'b110100;
      5'd12: base6 = 6'b001101;
      5'd13: base6 = 6'b101100;
      5'd14: base6 = 6'b011100;
      5'd15: base6 = 6'b010111;
      5'd16: base6 = 6'b011011;
      5'd17: base6 = 6'b100011;
      5'd18: base6 = 6'b010011;
      5'd19: base6 = 6'b110010;
      5'd20: base6 = 6'b001011;
      5'd21: base6 = 6'b101010;
      5'd22: base6 = 6'b011010;
      5'd23: base6 = 6'b111010;
      5'd24: base6 = 6'b110011;
      5'd25: base6 = 6'b100110;
      5'd26: base6 = 6'b010110;
      5'd27: base6 = 6'b110110;
      5'd28: base6 = isK ? 6'b001111 : 6'b001110;
      5'd29: base6 = 6'b101110;
      5'd30: base6 = 6'b011110;
      default: base6 = 6'b101011;
    endcase
  end

  assign unbal6 = ($countones(base6) != 3);

  // D.07 is balanced but still alternates
  assign sub6 = (rd == dispPos && (unbal6 || x5 == 5'd7)) ? ~base6 : base6;
  assign rd6  = unbal6 ? ((rd == dispPos) ? dispNeg : dispPos) : rd;

  // Alternate 7 avoids a run of five, and K.x.7 always takes it
  assign useA7 = isK
              || (rd6 == dispNeg && (x5 inside {5'd17, 5'd18, 5'd20}))
              || (rd6 == dispPos && (x5 inside {5'd11, 5'd13, 5'd14}));

  // 3b/4b, fghj forms for negative disparity
  always_comb
  begin
    case (y3)
      3'd0:    base4 = 4'b1011;
      3'd1:    base4 = 4'b1001;
      3'd2:    base4 = 4'b0101;
      3'd3:    base4 = 4'b1100;
      3'd4:    base4 = 4'b1101;
      3'd5:    base4 = 4'b1010;
      3'd6:    base4 = 4'b0110;
      default: base4 = useA7 ? 4'b0111 : 4'b1110;
    endcase
  end

  assign unbal4 = ($countones(base4) != 2);

  // Balanced K forms for y 1, 2, 5, 6 are inverted against data
  assign flip4 = (unbal4 || y3 == 3'd3) ? (rd6 == dispPos)
                                        : (isK && rd6 == dispNeg);
  assign sub4   = flip4 ? ~base4 : base4;
  assign rdNext = unbal4 ? ((rd6 == dispPos) ? dispNeg : dispPos) : rd6;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      rd        <= dispNeg;
      codeValid <= 1'b0;
    end
    else
    begin
      codeValid <= valid;
      if (valid)
        rd <= rdNext;
    end
  end

  // Word is abcdei in [9:4], fghj in [3:0], a sent first
  always_ff @(posedge clk)
  begin
    if (valid)
      code <= {sub6, sub4};
  end

  codeOnesA: assert property (@(posedge clk) disable iff (!rstN)
      codeValid |-> ($countones(code) >= 4 && $countones(code) <= 6))
    else $error("Encoded word with %0d ones", $countones(code));

endmodule

// ==== design/enc8b10b_wrap.sv ====
//**************************************************************************
// E-link framing encoder
// Maps the frame code to a data byte or a K28 control character and
// passes it to the 8b/10b encoder on the ready strobe
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module enc8b10b_wrap
  import enc8b10b_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`ENC_DATA_W-1:0] dataIn,
  input  frameCodeT              dataCode,
  input  logic                   dataInRdy,
  output logic [`ENC_CODE_W-1:0] encDataOut,
  output logic                   encDataOutRdy
);

  logic [`ENC_DATA_W-1:0] byteOut;
  logic                   isK;

  // Control codes ignore dataIn
  always_comb
  begin
    case (dataCode)
      codeSop:
      begin
        byteOut = `K_SOP;
        isK     = 1'b1;
      end
      codeEop:
      begin
        byteOut = `K_EOP;
        isK     = 1'b1;
      end
      codeComma:
      begin
        byteOut = `K_COMMA;
        isK     = 1'b1;
      end
      default:
      begin
        byteOut = dataIn;
        isK     = 1'b0;
      end
    endcase
  end

  enc8b10b encI
  (
    .clk       (clk),
    .rstN      (rstN),
    .byteIn    (byteOut),
    .isK       (isK),
    .valid     (dataInRdy),
    .code      (encDataOut),
    .codeValid (encDataOutRdy)
  );

  // One symbol out for every strobe, one cycle later
  property rdyLatencyP;
    @(posedge clk) disable iff (!rstN)
      dataInRdy |=> encDataOutRdy;
  endproperty

  rdyLatencyA: assert property (rdyLatencyP)
    else $error("encDataOutRdy not seen one cycle after dataInRdy");

endmodule

// ==== design/dec8b10b.sv ====
//**************************************************************************
// 8b/10b decoder
// Reverses the sub-block tables, flags K characters, code errors and
// running disparity errors, registered with one-cycle valid
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module dec8b10b
  import enc8b10b_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`ENC_CODE_W-1:0] linkData,
  input  logic                   linkValid,
  output logic [`ENC_DATA_W-1:0] dataOut,
  output logic                   ko,
  output logic                   codeErr,
  output logic                   dispErr,
  output logic                   decValid
);

  dispT       rd;
  logic [5:0] w6;
  logic [3:0] w4;
  logic [5:0] f6;
  logic [3:0] w4n;
  logic [3:0] f4;
  logic [4:0] x5;
  logic [2:0] y3;
  logic [3:0] onesAll;
  logic       ok6;
  logic       ok4;
  logic       isA7;
  logic       isK28;
  logic       kAlt;
  logic       a7Err;
  logic       wordPos;
  logic       wordNeg;
  logic       badCode;
  logic       badDisp;

  assign w6      = linkData[9:4];
  assign w4      = linkData[3:0];
  assign onesAll = 4'($countones(linkData));
  assign isK28   = (w6 == 6'b001111) || (w6 == 6'b110000);

  // Positive forms of unbalanced 6b blocks have two ones
  assign f6 = ($countones(w6) == 2) ? ~w6 : w6;

  always_comb
  begin
    ok6 = 1'b1;
    case (f6)
      6'b100111: x5 = 5'd0;
      6'b011101: x5 = 5'd1;
      6'b101101: x5 = 5'd2;
      6'b110001: x5 = 5'd3;
      6'b110101: x5 = 5'd4;
      6'b101001: x5 = 5'd5;
      6'b011001: x5 = 5'd6;
      6'b111000: x5 = 5'd7;
      6'b000111: x5 = 5'd7;
      6'b111001: x5 = 5'd8;
      6'b100101: x5 = 5'd9;
      6'b010101: x5 = 5'd10;
      6'b110100: x5 = 5'd11;
      6'b001101: x5 = 5'd12;
      6'b101100: x5 = 5'd13;
      6'b011100: x5 = 5'd14;
      6'b010111: x5 = 5'd15;
      6'b011011: x5 = 5'd16;
      6'b100011: x5 = 5'd17;
      6'b010011: x5 = 5'd18;
      6'b110010: x5 = 5'd19;
      6'b001011: x5 = 5'd20;
      6'b101010: x5 = 5'd21;
      6'b011010: x5 = 5'd22;
      6'b111010: x5 = 5'd23;
      6'b110011: x5 = 5'd24;
      6'b100110: x5 = 5'd25;
      6'b010110: x5 = 5'd26;
      6'b110110: x5 = 5'd27;
      6'b001110: x5 = 5'd28;
      6'b001111: x5 = 5'd28;
      6'b101110: x5 = 5'd29;
      6'b011110: x5 = 5'd30;
      6'b101011: x5 = 5'd31;
      default:
      begin
        x5  = 5'd0;
        ok6 = 1'b0;
      end
    endcase
  end

  // After 110000 the K28 4b block sits in the other column
  assign w4n = (w6 == 6'b110000) ? ~w4 : w4;
  assign f4  = ($countones(w4n) == 1) ? ~w4n : w4n;

  always_comb
  begin
    ok4  = 1'b1;
    isA7 = 1'b0;
    case (f4)
      4'b1011: y3 = 3'd0;
      4'b1001: y3 = 3'd1;
      4'b0101: y3 = 3'd2;
      4'b1100: y3 = 3'd3;
      4'b0011: y3 = 3'd3;
      4'b1101: y3 = 3'd4;
      4'b1010: y3 = 3'd5;
      4'b0110: y3 = 3'd6;
      4'b1110: y3 = 3'd7;
      4'b0111:
      begin
        y3   = 3'd7;
        isA7 = 1'b1;
      end
      default:
      begin
        y3  = 3'd0;
        ok4 = 1'b0;
      end
    endcase
  end

  // K.23.7, K.27.7, K.29.7 and K.30.7 use the alternate 7
  assign kAlt  = isA7 && (x5 inside {5'd23, 5'd27, 5'd29, 5'd30});
  assign a7Err = isA7 && !isK28 && !kAlt
              && !(x5 inside {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20});

  assign wordPos = (onesAll == 4'd6);
  assign wordNeg = (onesAll == 4'd4);
  assign badCode = !ok6 || !ok4 || a7Err || (onesAll < 4'd4) || (onesAll > 4'd6);
  assign badDisp = (wordPos && rd == dispPos) || (wordNeg && rd == dispNeg);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      rd       <= dispNeg;
      decValid <= 1'b0;
      ko       <= 1'b0;
      codeErr  <= 1'b0;
      dispErr  <= 1'b0;
    end
    else
    begin
      decValid <= linkValid;
      if (linkValid)
      begin
        ko      <= isK28 || kAlt;
        codeErr <= badCode;
        dispErr <= badDisp;
        // Balanced words leave the disparity alone
        if (wordPos)
          rd <= dispPos;
        else if (wordNeg)
          rd <= dispNeg;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (linkValid)
      dataOut <= {y3, x5};
  end

  decLatencyA: assert property (@(posedge clk) disable iff (!rstN)
      linkValid |=> decValid)
    else $error("decValid not seen one cycle after linkValid");

endmodule

// ==== design/elink_codec_top.sv ====
//**************************************************************************
// E-link codec top level
// Framing encoder and decoder side by side, link loop closed outside
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module elink_codec_top
  import enc8b10b_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`ENC_DATA_W-1:0] dataIn,
  input  frameCodeT              dataCode,
  input  logic                   dataInRdy,
  output logic [`ENC_CODE_W-1:0] encDataOut,
  output logic                   encDataOutRdy,
  input  logic [`ENC_CODE_W-1:0] linkData,
  input  logic                   linkValid,
  output logic [`ENC_DATA_W-1:0] dataOut,
  output logic                   ko,
  output logic                   codeErr,
  output logic                   dispErr,
  output logic                   decValid
);

  // Transmit side
  enc8b10b_wrap encWrapI
  (
    .clk           (clk),
    .rstN          (rstN),
    .dataIn        (dataIn),
    .dataCode      (dataCode),
    .dataInRdy     (dataInRdy),
    .encDataOut    (encDataOut),
    .encDataOutRdy (encDataOutRdy)
  );

  // Receive side
  dec8b10b decI
  (
    .clk       (clk),
    .rstN      (rstN),
    .linkData  (linkData),
    .linkValid (linkValid),
    .dataOut   (dataOut),
    .ko        (ko),
    .codeErr   (codeErr),
    .dispErr   (dispErr),
    .decValid  (decValid)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
//**************************************************************************
// Testbench clock and reset
// 20 ns clock, synchronous active-low reset held for 5 cycles
//**************************************************************************

`timescale 1ns/10ps

module tb_clk_gen
(
  output logic clk,
  output logic rstN
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    rstN = 1'b0;
    for (int n = 0; n < 5; n++)
      @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// ==== tb/elink_checker.sv ====
//**************************************************************************
// E-link codec checker
// Compares decoded symbols with queued expectations, checks latency,
// word ones counts and running disparity, counts errors
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module elink_checker
  import enc8b10b_pkg::*;
(
  input logic                   clk,
  input logic                   rstN,
  input logic                   dataInRdy,
  input logic [`ENC_CODE_W-1:0] encDataOut,
  input logic                   encDataOutRdy,
  input logic [`ENC_DATA_W-1:0] dataOut,
  input logic                   ko,
  input logic                   codeErr,
  input logic                   dispErr,
  input logic                   decValid
);

  typedef struct {
    logic [`ENC_DATA_W-1:0] byteVal;
    logic                   kVal;
    logic                   cErr;
    logic                   dErr;
    logic                   checkSym;
  } expT;

  expT expQ[$];
  int  encQ[$];
  int  decQ[$];
  int  cycle    = 0;
  int  runDisp  = -1;
  int  errCount = 0;
  int  symCount = 0;

  task automatic pushExpected(input expT e);
    expQ.push_back(e);
  endtask

  function automatic int pendingCount();
    return expQ.size();
  endfunction

  task automatic reportValue(input string name, input logic [9:0] expV, input logic [9:0] gotV);
    $display("ERR %0t %s expected %h got %h", $time, name, expV, gotV);
    errCount++;
  endtask

  task automatic reportProblem(input string msg);
    $display("%0t %s", $time, msg);
    errCount++;
  endtask

  always @(posedge clk)
  begin
    expT e;
    int  ones;
    int  stamp;
    // Nothing may come out while reset is held
    if (!rstN && cycle > 0 && (decValid !== 1'b0 || encDataOutRdy !== 1'b0))
      reportProblem("Output strobe seen during reset");
    if (rstN && dataInRdy === 1'b1)
    begin
      encQ.push_back(cycle);
      decQ.push_back(cycle);
    end
    if (rstN && encDataOutRdy === 1'b1)
    begin
      ones = $countones(encDataOut);
      if (ones < 4 || ones > 6)
        reportValue("encDataOut ones", 10'd5, 10'(ones));
      runDisp = runDisp + 2 * (ones - 5);
      if (runDisp != 1 && runDisp != -1)
        reportProblem("Running disparity left the range of plus or minus one");
      if (encQ.size() == 0)
        reportProblem("Encoded word without a strobe");
      else
      begin
        stamp = encQ.pop_front();
        if (cycle - stamp != 1)
          reportProblem("encDataOutRdy not one cycle after dataInRdy");
      end
    end
    if (rstN && decValid === 1'b1)
    begin
      if (expQ.size() == 0 || decQ.size() == 0)
        reportProblem("decValid with no symbol in flight");
      else
      begin
        e     = expQ.pop_front();
        stamp = decQ.pop_front();
        symCount++;
        if (cycle - stamp != 2)
          reportProblem("decValid not two cycles after dataInRdy");
        if (e.checkSym && dataOut !== e.byteVal)
          reportValue("dataOut", {2'b00, e.byteVal}, {2'b00, dataOut});
        if (e.checkSym && ko !== e.kVal)
          reportValue("ko", {9'd0, e.kVal}, {9'd0, ko});
        if (codeErr !== e.cErr)
          reportValue("codeErr", {9'd0, e.cErr}, {9'd0, codeErr});
        if (dispErr !== e.dErr)
          reportValue("dispErr", {9'd0, e.dErr}, {9'd0, dispErr});
      end
    end
    cycle++;
  end

endmodule

// ==== tb/tb_elink_codec.sv ====
//**************************************************************************
// E-link codec testbench
// Applies a table of framed symbols, closes the link loop with optional
// word corruption and checks the decoded stream
//**************************************************************************

`timescale 1ns/10ps
`include "enc8b10b_config.svh"

module tb_elink_codec
  import enc8b10b_pkg::*;
();

  typedef enum logic [1:0] {corruptNone, corruptZero, corruptRepeat} corruptT;

  typedef struct {
    frameCodeT  code;
    logic [7:0] byteVal;
    corruptT    mode;
    int         gap;
  } rowT;

  logic       clk;
  logic       rstN;
  logic [7:0] dataIn;
  frameCodeT  dataCode;
  logic       dataInRdy;
  logic [9:0] encDataOut;
  logic       encDataOutRdy;
  logic [9:0] linkData;
  logic       linkValid;
  logic [7:0] dataOut;
  logic       ko;
  logic       codeErr;
  logic       dispErr;
  logic       decValid;

  rowT        rows[$];
  logic [31:0] lfsr      = 32'hfe78;
  corruptT    curMode    = corruptNone;
  corruptT    linkMode   = corruptNone;
  logic [9:0] lastUnbal  = 10'h000;
  logic       timedOut;

  tb_clk_gen clkGenI (.clk(clk), .rstN(rstN));

  elink_codec_top dut_i
  (
    .clk(clk), .rstN(rstN), .dataIn(dataIn), .dataCode(dataCode),
    .dataInRdy(dataInRdy), .encDataOut(encDataOut), .encDataOutRdy(encDataOutRdy),
    .linkData(linkData), .linkValid(linkValid), .dataOut(dataOut), .ko(ko),
    .codeErr(codeErr), .dispErr(dispErr), .decValid(decValid)
  );

  elink_checker checkI
  (
    .clk(clk), .rstN(rstN), .dataInRdy(dataInRdy), .encDataOut(encDataOut),
    .encDataOutRdy(encDataOutRdy), .dataOut(dataOut), .ko(ko), .codeErr(codeErr),
    .dispErr(dispErr), .decValid(decValid)
  );

  // Corrupt mode reaches the loopback one cycle behind the strobe
  assign linkValid = (encDataOutRdy === 1'b1);
  assign linkData  = !linkValid                 ? 10'h000 :
                     (linkMode == corruptZero)   ? 10'h000 :
                     (linkMode == corruptRepeat) ? lastUnbal : encDataOut;

  always @(posedge clk)
  begin
    linkMode <= curMode;
    if (linkValid && ($countones(linkData) == 4 || $countones(linkData) == 6))
      lastUnbal <= linkData;
  end

  // Galois LFSR stepped once per bit
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr   = lfsr >> 1;
    if (outBit)
      lfsr = lfsr ^ 32'h80200003;
    return outBit;
  endfunction

  function automatic logic [7:0] randomByte();
    logic [7:0] b;
    b = 8'h00;
    for (int n = 0; n < 8; n++)
      b = {b[6:0], nextBit()};
    return b;
  endfunction

  task automatic addRow(input frameCodeT c, input logic [7:0] b, input corruptT m,
                        input int gap);
    rowT r;
    r.code    = c;
    r.byteVal = b;
    r.mode    = m;
    r.gap     = gap;
    rows.push_back(r);
  endtask

  // D.03.1 is balanced, so corrupting it keeps both disparities in step
  task automatic buildRows();
    addRow(codeSop, 8'h00, corruptNone, 1);
    addRow(codeData, 8'hDE, corruptNone, 0);
    addRow(codeData, 8'hAD, corruptNone, 0);
    addRow(codeData, 8'hBE, corruptNone, 0);
    addRow(codeData, 8'hEF, corruptNone, 0);
    addRow(codeEop, 8'h00, corruptNone, 2);
    addRow(codeComma, 8'h00, corruptNone, 1);
    for (int n = 0; n < 32; n++)
      addRow(codeData, randomByte(), corruptNone, {30'd0, nextBit(), nextBit()});
    addRow(codeComma, 8'h00, corruptNone, 2);
    addRow(codeData, 8'h23, corruptZero, 2);
    addRow(codeData, 8'h5A, corruptNone, 1);
    addRow(codeData, 8'h23, corruptRepeat, 2);
    addRow(codeData, 8'hA5, corruptNone, 0);
    addRow(codeEop, 8'h00, corruptNone, 3);
  endtask

  task automatic applyRows();
    logic [7:0] eByte;
    for (int i = 0; i < rows.size(); i++)
    begin
      @(posedge clk);
      dataIn    <= rows[i].byteVal;
      dataCode  <= rows[i].code;
      dataInRdy <= 1'b1;
      curMode   <= rows[i].mode;
      case (rows[i].code)
        codeSop:   eByte = `K_SOP;
        codeEop:   eByte = `K_EOP;
        codeComma: eByte = `K_COMMA;
        default:   eByte = rows[i].byteVal;
      endcase
      checkI.pushExpected('{byteVal: eByte, kVal: (rows[i].code != codeData),
                            cErr: (rows[i].mode == corruptZero),
                            dErr: (rows[i].mode == corruptRepeat),
                            checkSym: (rows[i].mode == corruptNone)});
      for (int g = 0; g < rows[i].gap; g++)
      begin
        @(posedge clk);
        dataInRdy <= 1'b0;
        curMode   <= corruptNone;
      end
    end
    @(posedge clk);
    dataInRdy <= 1'b0;
    curMode   <= corruptNone;
  endtask

  initial
  begin
    int waitCnt;
    dataIn    = 8'h00;
    dataCode  = codeData;
    dataInRdy = 1'b0;
    timedOut  = 1'b0;
    buildRows();
    waitCnt = 0;
    while (rstN !== 1'b1 && waitCnt < 20)
    begin
      @(posedge clk);
      waitCnt++;
    end
    if (rstN !== 1'b1)
    begin
      $display("Timeout waiting for reset to be released");
      timedOut = 1'b1;
    end
    else
    begin
      applyRows();
      waitCnt = 0;
      while (checkI.pendingCount() != 0 && waitCnt < 20)
      begin
        @(posedge clk);
        waitCnt++;
      end
      if (checkI.pendingCount() != 0)
      begin
        $display("Timeout waiting for %0d decoded symbols", checkI.pendingCount());
        timedOut = 1'b1;
      end
    end
    $display("Symbols checked %0d, errors %0d, timeouts %0d",
             checkI.symCount, checkI.errCount, timedOut);
    if (timedOut || checkI.errCount != 0)
      $display("Test failed");
    else
      $display("Test passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+design
design/enc8b10b_pkg.sv
design/enc8b10b.sv
design/enc8b10b_wrap.sv
design/dec8b10b.sv
design/elink_codec_top.sv
tb/tb_clk_gen.sv
tb/elink_checker.sv
tb/tb_elink_codec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the e-link codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
  --top-module tb_elink_codec --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOut" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
